/* all.f */
+incdir+sim
rtl/drac_pkg.sv
rtl/espm_frame_rx.sv
rtl/board_health.sv
rtl/encoder_preload.sv
rtl/block_sampler.sv
rtl/reg_read_arbiter.sv
rtl/drac_core.sv
sim/tb_drac.sv

/* rtl/block_sampler.sv */
// Block sampler
`timescale 1ns/1ps
`default_nettype none

module block_sampler
    import drac_pkg::*;
#(
    parameter int SAMPLE_WORDS = 8,
    parameter int SAMP_IDX_W   = $clog2(SAMPLE_WORDS)
) (
    input  logic                  sysclk,
    input  logic                  arst_n_i,
    input  logic                  sample_start_i,
    input  logic [DATA_W-1:0]     reg_rdata_i,
    output logic                  samp_active_o,
    output logic [ADDR_W-1:0]     samp_raddr_o,
    input  logic [SAMP_IDX_W-1:0] sample_raddr_i,
    output logic [DATA_W-1:0]     sample_rdata_o
);

    logic [DATA_W-1:0]   samp_buf [SAMPLE_WORDS];
    logic [SAMP_IDX_W:0] step;      // One extra step to catch the last word
    reg_addr_u           saddr;

    // Entry 0 is the health word, then adjusted positions
    always_comb begin
        saddr = '0;
        if (step[SAMP_IDX_W-1:0] == '0) begin
            saddr.board.region = REGION_BOARD;
            saddr.board.idx    = BRD_HEALTH;
        end else begin
            saddr.main.region = REGION_MAIN;
            saddr.main.chan   = 4'(step[SAMP_IDX_W-1:0]);
            saddr.main.off    = OFF_ENC_DATA;
        end
    end

    assign samp_raddr_o = saddr;

    always_ff @(posedge sysclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            samp_active_o <= 1'b0;
            step          <= '0;
        end else if (samp_active_o) begin
            step <= step + 1'b1;
            if (step == (SAMP_IDX_W+1)'(SAMPLE_WORDS)) begin
                samp_active_o <= 1'b0;
            end
        end else if (sample_start_i) begin
            samp_active_o <= 1'b1;
            step          <= '0;
        end
    end

    // Read data lags the address by one cycle
    always_ff @(posedge sysclk) begin
        if (samp_active_o && (step != '0)) begin
            samp_buf[SAMP_IDX_W'(step - 1'b1)] <= reg_rdata_i;
        end
    end

    assign sample_rdata_o = samp_buf[sample_raddr_i];

    a_no_start_while_busy : assert property (
        @(posedge sysclk) disable iff (!arst_n_i) samp_active_o |-> !sample_start_i
    );

endmodule

`default_nettype wire

/* rtl/board_health.sv */
// Communication watchdog and supply window
`timescale 1ns/1ps
`default_nettype none

module board_health
    import drac_pkg::*;
#(
    parameter int          WDOG_PERIOD = 400,
    parameter int unsigned MV_MIN      = 32913,
    parameter int unsigned MV_MAX      = 40227
) (
    input  logic                 sysclk,
    input  logic                 arst_n_i,
    input  logic [CNT_CMP_W-1:0] good_count_i,
    input  logic                 mv_sample_valid_i,
    input  logic [MV_W-1:0]      mv_sample_i,
    output logic                 comm_good_o,
    output logic                 mv_good_o,
    output logic [MV_W-1:0]      mv_value_o
);

    localparam int WD_W = $clog2(WDOG_PERIOD);

    logic [WD_W-1:0]      wdog_cnt;
    logic                 wdog_tick;
    logic [CNT_CMP_W-1:0] cnt_snap;     // Count at previous tick

    assign wdog_tick = (wdog_cnt == WD_W'(WDOG_PERIOD - 1));

    always_ff @(posedge sysclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wdog_cnt <= '0;
        end else if (wdog_tick) begin
            wdog_cnt <= '0;
        end else begin
            wdog_cnt <= wdog_cnt + 1'b1;
        end
    end

    // Healthy if any good frame arrived during the last period
    always_ff @(posedge sysclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt_snap    <= '0;
            comm_good_o <= 1'b0;
        end else if (wdog_tick) begin
            cnt_snap    <= good_count_i;
            comm_good_o <= (good_count_i != cnt_snap);
        end
    end

    // ------------------------------------------------------------------------
    // Motor supply
    // ------------------------------------------------------------------------

    always_ff @(posedge sysclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mv_value_o <= '0;
        end else if (mv_sample_valid_i) begin
            mv_value_o <= mv_sample_i;
        end
    end

    assign mv_good_o = (32'(mv_value_o) > MV_MIN) && (32'(mv_value_o) < MV_MAX);

endmodule

`default_nettype wire

/* rtl/drac_core.sv */
// DRAC sensing and register core
`timescale 1ns/1ps
`default_nettype none

module drac_core
    import drac_pkg::*;
#(
    parameter int          WDOG_PERIOD = 400,
    parameter int unsigned MV_MIN      = 32913,
    parameter int unsigned MV_MAX      = 40227,
    parameter int          SAMPLE_WORDS = 8,
    parameter int          SAMP_IDX_W   = $clog2(SAMPLE_WORDS)
) (
    input  logic                  sysclk,
    input  logic                  arst_n_i,
    // ESPM receive strobes
    input  logic                  rx_word_valid_i,
    input  logic [ESPM_IDX_W-1:0] rx_word_idx_i,
    input  logic [DATA_W-1:0]     rx_word_i,
    input  logic                  rx_eof_i,
    input  logic                  rx_crc_good_i,
    // Supply ADC
    input  logic                  mv_sample_valid_i,
    input  logic [MV_W-1:0]       mv_sample_i,
    // Host register bus
    input  logic [ADDR_W-1:0]     reg_raddr_i,
    input  logic [ADDR_W-1:0]     reg_waddr_i,
    input  logic [DATA_W-1:0]     reg_wdata_i,
    input  logic                  reg_wen_i,
    output logic [DATA_W-1:0]     reg_rdata_o,
    // Sampler
    input  logic                  sample_start_i,
    input  logic [SAMP_IDX_W-1:0] sample_raddr_i,
    output logic                  sample_busy_o,
    output logic [DATA_W-1:0]     sample_rdata_o,
    // Status
    output logic                  comm_good_o,
    output logic                  mv_good_o,
    output logic                  preload_good_o
);

    logic [ESPM_IDX_W-1:0]       live_raddr;
    logic [DATA_W-1:0]           live_rdata;
    logic [NUM_ENC:1][ENC_W-1:0] pos_word;
    logic [DATA_W-1:0]           good_count;
    logic [DATA_W-1:0]           err_count;
    logic [MV_W-1:0]             mv_value;
    logic [3:0]                  rd_chan;
    logic [3:0]                  rd_off;
    logic [DATA_W-1:0]           enc_rdata;
    logic [ADDR_W-1:0]           samp_raddr;

    espm_frame_rx u_frame_rx (
        .sysclk          (sysclk),
        .arst_n_i        (arst_n_i),
        .rx_word_valid_i (rx_word_valid_i),
        .rx_word_idx_i   (rx_word_idx_i),
        .rx_word_i       (rx_word_i),
        .rx_eof_i        (rx_eof_i),
        .rx_crc_good_i   (rx_crc_good_i),
        .live_raddr_i    (live_raddr),
        .live_rdata_o    (live_rdata),
        .pos_word_o      (pos_word),
        .preload_good_o  (preload_good_o),
        .good_count_o    (good_count),
        .err_count_o     (err_count)
    );

    board_health #(
        .WDOG_PERIOD (WDOG_PERIOD),
        .MV_MIN      (MV_MIN),
        .MV_MAX      (MV_MAX)
    ) u_health (
        .sysclk            (sysclk),
        .arst_n_i          (arst_n_i),
        .good_count_i      (good_count[CNT_CMP_W-1:0]),
        .mv_sample_valid_i (mv_sample_valid_i),
        .mv_sample_i       (mv_sample_i),
        .comm_good_o       (comm_good_o),
        .mv_good_o         (mv_good_o),
        .mv_value_o        (mv_value)
    );

    encoder_preload u_preload (
        .sysclk      (sysclk),
        .arst_n_i    (arst_n_i),
        .reg_waddr_i (reg_waddr_i),
        .reg_wdata_i (reg_wdata_i),
        .reg_wen_i   (reg_wen_i),
        .pos_word_i  (pos_word),
        .rd_chan_i   (rd_chan),
        .rd_off_i    (rd_off),
        .enc_rdata_o (enc_rdata)
    );

    block_sampler #(
        .SAMPLE_WORDS (SAMPLE_WORDS),
        .SAMP_IDX_W   (SAMP_IDX_W)
    ) u_sampler (
        .sysclk         (sysclk),
        .arst_n_i       (arst_n_i),
        .sample_start_i (sample_start_i),
        .reg_rdata_i    (reg_rdata_o),
        .samp_active_o  (sample_busy_o),
        .samp_raddr_o   (samp_raddr),
        .sample_raddr_i (sample_raddr_i),
        .sample_rdata_o (sample_rdata_o)
    );

    reg_read_arbiter u_arbiter (
        .sysclk         (sysclk),
        .arst_n_i       (arst_n_i),
        .reg_raddr_i    (reg_raddr_i),
        .samp_active_i  (sample_busy_o),
        .samp_raddr_i   (samp_raddr),
        .live_raddr_o   (live_raddr),
        .live_rdata_i   (live_rdata),
        .rd_chan_o      (rd_chan),
        .rd_off_o       (rd_off),
        .enc_rdata_i    (enc_rdata),
        .good_count_i   (good_count),
        .err_count_i    (err_count),
        .mv_value_i     (mv_value),
        .comm_good_i    (comm_good_o),
        .mv_good_i      (mv_good_o),
        .preload_good_i (preload_good_o),
        .reg_rdata_o    (reg_rdata_o)
    );

endmodule

`default_nettype wire

/* rtl/drac_pkg.sv */
// DRAC shared definitions
`default_nettype none

package drac_pkg;

    // Bus widths
    localparam int ADDR_W = 16;
    localparam int DATA_W = 32;
    localparam int MV_W   = 16;                 // Supply ADC sample

    // ESPM frame layout
    localparam int ESPM_WORDS       = 64;
    localparam int ESPM_IDX_W       = 6;
    localparam int ESPM_POS_BASE    = 8;        // Word 8+k is channel k position
    localparam int ESPM_PRELOAD_IDX = 34;       // Bit 0 is preload valid

    // Encoder channels
    localparam int NUM_ENC   = 7;
    localparam int ENC_W     = 24;
    localparam int CNT_CMP_W = 10;              // Good-frame bits seen by watchdog

    // ------------------------------------------------------------------------
    // Address map
    // ------------------------------------------------------------------------

    localparam logic [3:0] REGION_MAIN  = 4'h0;
    localparam logic [3:0] REGION_BOARD = 4'hB;
    localparam logic [3:0] REGION_ESPM  = 4'hE;

    localparam logic [3:0] OFF_ENC_LOAD = 4'd4; // Preload readback
    localparam logic [3:0] OFF_ENC_DATA = 4'd5; // Adjusted position

    localparam logic [11:0] BRD_CRC_ERR  = 12'h000;
    localparam logic [11:0] BRD_CRC_GOOD = 12'h001;
    localparam logic [11:0] BRD_MV       = 12'h002;
    localparam logic [11:0] BRD_HEALTH   = 12'h003;
    localparam logic [11:0] BRD_BUILD    = 12'hFFF;

    localparam logic [DATA_W-1:0] BUILD_NUMBER = 32'd2;
    localparam logic [DATA_W-1:0] FILL_WORD    = 32'h0000_CCCC;

    // One register address, decoded per region
    typedef union packed {
        struct packed {
            logic [3:0] region;
            logic [3:0] rsvd;
            logic [3:0] chan;
            logic [3:0] off;
        } main;
        struct packed {
            logic [3:0]  region;
            logic [11:0] idx;
        } board;
    } reg_addr_u;

endpackage

`default_nettype wire

/* rtl/encoder_preload.sv */
// Encoder preload and adjusted position
`timescale 1ns/1ps
`default_nettype none

module encoder_preload
    import drac_pkg::*;
(
    input  logic                          sysclk,
    input  logic                          arst_n_i,
    input  logic [ADDR_W-1:0]             reg_waddr_i,
    input  logic [DATA_W-1:0]             reg_wdata_i,
    input  logic                          reg_wen_i,
    input  logic [NUM_ENC:1][ENC_W-1:0]   pos_word_i,
    input  logic [3:0]                    rd_chan_i,
    input  logic [3:0]                    rd_off_i,
    output logic [DATA_W-1:0]             enc_rdata_o
);

    localparam logic [ENC_W-1:0] ENC_MIDRANGE = {1'b1, {(ENC_W-1){1'b0}}};
    localparam int               OVF_BITS     = 12;

    reg_addr_u                   waddr;
    logic                        load_hit;
    logic                        rd_chan_ok;
    logic [NUM_ENC:1][ENC_W-1:0] preload;
    logic [NUM_ENC:1][ENC_W-1:0] offset;
    logic [NUM_ENC:1][ENC_W-1:0] enc_sum;
    logic [NUM_ENC:1]            ovf;

    assign waddr    = reg_waddr_i;
    assign load_hit = reg_wen_i && (waddr.main.region == REGION_MAIN)
                      && (waddr.main.off == OFF_ENC_LOAD)
                      && (waddr.main.chan >= 4'd1)
                      && (waddr.main.chan <= 4'(NUM_ENC));

    always_comb begin
        for (int k = 1; k <= NUM_ENC; k++) begin
            enc_sum[k] = pos_word_i[k] + offset[k];   // Wraps at 24 bits
        end
    end

    always_ff @(posedge sysclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            preload <= {NUM_ENC{ENC_MIDRANGE}};
            offset  <= '0;
            ovf     <= '0;
        end else if (load_hit) begin
            preload[waddr.main.chan] <= reg_wdata_i[ENC_W-1:0];
            offset[waddr.main.chan]  <= reg_wdata_i[ENC_W-1:0] - pos_word_i[waddr.main.chan];
            ovf[waddr.main.chan]     <= 1'b0;
        end else begin
            // Sticky flag near either end of the range
            for (int k = 1; k <= NUM_ENC; k++) begin
                if ((enc_sum[k][ENC_W-1 -: OVF_BITS] == '0) ||
                    (enc_sum[k][ENC_W-1 -: OVF_BITS] == '1)) begin
                    ovf[k] <= 1'b1;
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read data for the arbiter
    // ------------------------------------------------------------------------

    assign rd_chan_ok = (rd_chan_i >= 4'd1) && (rd_chan_i <= 4'(NUM_ENC));

    always_comb begin
        enc_rdata_o = FILL_WORD;
        if (rd_chan_ok) begin
            case (rd_off_i)
                OFF_ENC_LOAD: enc_rdata_o = DATA_W'(preload[rd_chan_i]);
                OFF_ENC_DATA: enc_rdata_o = {{(DATA_W-ENC_W-1){1'b0}},
                                             ovf[rd_chan_i], enc_sum[rd_chan_i]};
                default:      enc_rdata_o = FILL_WORD;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/espm_frame_rx.sv */
// ESPM frame receiver
`timescale 1ns/1ps
`default_nettype none

module espm_frame_rx
    import drac_pkg::*;
(
    input  logic                           sysclk,
    input  logic                           arst_n_i,
    input  logic                           rx_word_valid_i,
    input  logic [ESPM_IDX_W-1:0]          rx_word_idx_i,
    input  logic [DATA_W-1:0]              rx_word_i,
    input  logic                           rx_eof_i,
    input  logic                           rx_crc_good_i,
    input  logic [ESPM_IDX_W-1:0]          live_raddr_i,
    output logic [DATA_W-1:0]              live_rdata_o,
    output logic [NUM_ENC:1][ENC_W-1:0]    pos_word_o,
    output logic                           preload_good_o,
    output logic [DATA_W-1:0]              good_count_o,
    output logic [DATA_W-1:0]              err_count_o
);

    logic [DATA_W-1:0]     stage_mem [ESPM_WORDS];  // Frame as received
    logic [DATA_W-1:0]     live_mem  [ESPM_WORDS];  // Last good frame
    logic                  copy_active;
    logic [ESPM_IDX_W-1:0] copy_idx;
    logic [DATA_W-1:0]     copy_word;

    assign copy_word = stage_mem[copy_idx];

    always_ff @(posedge sysclk) begin
        if (rx_word_valid_i) begin
            stage_mem[rx_word_idx_i] <= rx_word_i;
        end
        if (copy_active) begin
            live_mem[copy_idx] <= copy_word;
        end
        live_rdata_o <= live_mem[live_raddr_i];    // Synchronous read port
    end

    // ------------------------------------------------------------------------
    // Copy sequencer, one word per cycle after a good end of frame
    // ------------------------------------------------------------------------

    always_ff @(posedge sysclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            copy_active <= 1'b0;
            copy_idx    <= '0;
        end else if (copy_active) begin
            copy_idx <= copy_idx + 1'b1;
            if (copy_idx == ESPM_IDX_W'(ESPM_WORDS - 1)) begin
                copy_active <= 1'b0;
            end
        end else if (rx_eof_i && rx_crc_good_i) begin
            copy_active <= 1'b1;
            copy_idx    <= '0;
        end
    end

    // Decode positions and preload flag as words pass
    always_ff @(posedge sysclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pos_word_o     <= '0;
            preload_good_o <= 1'b0;
        end else if (copy_active) begin
            for (int k = 1; k <= NUM_ENC; k++) begin
                if (copy_idx == ESPM_IDX_W'(ESPM_POS_BASE + k)) begin
                    pos_word_o[k] <= copy_word[ENC_W-1:0];
                end
            end
            if (copy_idx == ESPM_IDX_W'(ESPM_PRELOAD_IDX)) begin
                preload_good_o <= copy_word[0];
            end
        end
    end

    // Frame counters
    always_ff @(posedge sysclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            good_count_o <= '0;
            err_count_o  <= '0;
        end else if (rx_eof_i) begin
            if (rx_crc_good_i) begin
                good_count_o <= good_count_o + 1'b1;
            end else begin
                err_count_o <= err_count_o + 1'b1;
            end
        end
    end

    // Next frame may not end before the copy is done
    a_no_eof_during_copy : assert property (
        @(posedge sysclk) disable iff (!arst_n_i) copy_active |-> !rx_eof_i
    );

endmodule

`default_nettype wire

/* rtl/reg_read_arbiter.sv */
// Register read port arbiter
`timescale 1ns/1ps
`default_nettype none

module reg_read_arbiter
    import drac_pkg::*;
(
    input  logic                  sysclk,
    input  logic                  arst_n_i,
    input  logic [ADDR_W-1:0]     reg_raddr_i,
    input  logic                  samp_active_i,
    input  logic [ADDR_W-1:0]     samp_raddr_i,
    output logic [ESPM_IDX_W-1:0] live_raddr_o,
    input  logic [DATA_W-1:0]     live_rdata_i,
    output logic [3:0]            rd_chan_o,
    output logic [3:0]            rd_off_o,
    input  logic [DATA_W-1:0]     enc_rdata_i,
    input  logic [DATA_W-1:0]     good_count_i,
    input  logic [DATA_W-1:0]     err_count_i,
    input  logic [MV_W-1:0]       mv_value_i,
    input  logic                  comm_good_i,
    input  logic                  mv_good_i,
    input  logic                  preload_good_i,
    output logic [DATA_W-1:0]     reg_rdata_o
);

    reg_addr_u         gaddr;       // Granted address
    logic              espm_q;
    logic [DATA_W-1:0] other_d;
    logic [DATA_W-1:0] other_q;

    // Sampler owns the port while it runs
    assign gaddr = samp_active_i ? samp_raddr_i : reg_raddr_i;

    assign live_raddr_o = gaddr.board.idx[ESPM_IDX_W-1:0];
    assign rd_chan_o    = gaddr.main.chan;
    assign rd_off_o     = gaddr.main.off;

    always_comb begin
        case (gaddr.board.region)
            REGION_MAIN: other_d = enc_rdata_i;
            REGION_BOARD: begin
                case (gaddr.board.idx)
                    BRD_CRC_ERR:  other_d = err_count_i;
                    BRD_CRC_GOOD: other_d = good_count_i;
                    BRD_MV:       other_d = DATA_W'(mv_value_i);
                    BRD_HEALTH:   other_d = DATA_W'({preload_good_i, comm_good_i, mv_good_i});
                    BRD_BUILD:    other_d = BUILD_NUMBER;
                    default:      other_d = FILL_WORD;
                endcase
            end
            default: other_d = FILL_WORD;       // ESPM comes from the live buffer
        endcase
    end

    // ------------------------------------------------------------------------
    // Registered stage, in step with the live buffer read
    // ------------------------------------------------------------------------

    always_ff @(posedge sysclk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            espm_q <= 1'b0;
        end else begin
            espm_q <= (gaddr.board.region == REGION_ESPM);
        end
    end

    always_ff @(posedge sysclk) begin
        other_q <= other_d;
    end

    assign reg_rdata_o = espm_q ? live_rdata_i : other_q;

endmodule

`default_nettype wire

/* sim/drac_model.svh */
// DRAC reference model
`ifndef DRAC_MODEL_SVH
`define DRAC_MODEL_SVH

logic [DATA_W-1:0] m_stage   [ESPM_WORDS];  // Frame being sent
logic [DATA_W-1:0] m_live    [ESPM_WORDS];  // Last good frame
logic [ENC_W-1:0]  m_pos     [1:NUM_ENC];
logic [ENC_W-1:0]  m_preload [1:NUM_ENC];
logic [ENC_W-1:0]  m_offset  [1:NUM_ENC];
logic              m_ovf     [1:NUM_ENC];
logic              m_preload_good;
logic              m_comm_good;
logic [MV_W-1:0]   m_mv;
int unsigned       m_good;
int unsigned       m_err;

// Top 12 bits all zeros or all ones
function automatic logic near_range_end(input logic [ENC_W-1:0] v);
    return (v[ENC_W-1 -: 12] == 12'h000) || (v[ENC_W-1 -: 12] == 12'hFFF);
endfunction

function automatic logic supply_ok(input logic [MV_W-1:0] v);
    return (int'(v) > MV_MIN) && (int'(v) < MV_MAX);
endfunction

task automatic reset_model();
    m_good         = 0;
    m_err          = 0;
    m_preload_good = 1'b0;
    m_comm_good    = 1'b0;
    m_mv           = '0;
    for (int i = 0; i < ESPM_WORDS; i++) begin
        m_live[i] = '0;
    end
    for (int k = 1; k <= NUM_ENC; k++) begin
        m_pos[k]     = '0;
        m_preload[k] = 24'h800000;              // Midrange
        m_offset[k]  = '0;
        m_ovf[k]     = 1'b1;                    // Zero sum sits at the low end
    end
endtask

task automatic commit_frame(input logic crc_ok);
    if (crc_ok) begin
        m_good++;
        for (int i = 0; i < ESPM_WORDS; i++) begin
            m_live[i] = m_stage[i];
        end
        for (int k = 1; k <= NUM_ENC; k++) begin
            m_pos[k] = m_stage[ESPM_POS_BASE + k][ENC_W-1:0];
            m_ovf[k] = m_ovf[k] | near_range_end(m_pos[k] + m_offset[k]);
        end
        m_preload_good = m_stage[ESPM_PRELOAD_IDX][0];
    end else begin
        m_err++;
    end
endtask

task automatic load_preload(input int chan, input logic [ENC_W-1:0] val);
    m_preload[chan] = val;
    m_offset[chan]  = val - m_pos[chan];
    m_ovf[chan]     = near_range_end(val);      // Sum equals the preload
endtask

function automatic logic [DATA_W-1:0] adjusted_word(input int chan);
    logic [ENC_W-1:0] sum;
    sum = m_pos[chan] + m_offset[chan];
    return {7'b0, m_ovf[chan], sum};
endfunction

function automatic logic [DATA_W-1:0] health_word();
    return {29'b0, m_preload_good, m_comm_good, supply_ok(m_mv)};
endfunction

`endif

/* sim/tb_drac.sv */
// DRAC core testbench
`timescale 1ns/1ps
`default_nettype none

module tb_drac
    import drac_pkg::*;
();

    localparam int WDOG_PERIOD  = 400;
    localparam int MV_MIN       = 32913;
    localparam int MV_MAX       = 40227;
    localparam int SAMPLE_WORDS = 8;

    logic                  sysclk;
    logic                  arst_n_i;
    logic                  rx_word_valid_i;
    logic [ESPM_IDX_W-1:0] rx_word_idx_i;
    logic [DATA_W-1:0]     rx_word_i;
    logic                  rx_eof_i;
    logic                  rx_crc_good_i;
    logic                  mv_sample_valid_i;
    logic [MV_W-1:0]       mv_sample_i;
    logic [ADDR_W-1:0]     reg_raddr_i;
    logic [ADDR_W-1:0]     reg_waddr_i;
    logic [DATA_W-1:0]     reg_wdata_i;
    logic                  reg_wen_i;
    logic [DATA_W-1:0]     reg_rdata_o;
    logic                  sample_start_i;
    logic [2:0]            sample_raddr_i;
    logic                  sample_busy_o;
    logic [DATA_W-1:0]     sample_rdata_o;
    logic                  comm_good_o;
    logic                  mv_good_o;
    logic                  preload_good_o;

    `include "drac_model.svh"

    drac_core #(
        .WDOG_PERIOD (WDOG_PERIOD),
        .MV_MIN      (MV_MIN),
        .MV_MAX      (MV_MAX)
    ) uut (.*);

    initial begin
        sysclk = 1'b0;
        forever #20 sysclk = ~sysclk;
    end

    task automatic check_equal(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] expected,
                               input string what);
        if (got !== expected) begin
            $display("[ERROR] %0t ns: %s read %h, expected %h", $time, what, got, expected);
            $display("SOME TESTS FAILED");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic timeout_fail(input string what);
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        $display("SOME TESTS FAILED");
        $fatal(1, "Timeout");
    endtask

    // Data comes back one cycle after the address
    task automatic expect_reg(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] expected,
                              input string what);
        @(posedge sysclk);
        reg_raddr_i <= addr;
        @(posedge sysclk);
        @(negedge sysclk);
        check_equal(reg_rdata_o, expected, what);
    endtask

    task automatic send_frame(input logic crc_ok);
        for (int i = 0; i < ESPM_WORDS; i++) begin
            m_stage[i] = $urandom;
        end
        for (int i = 0; i < ESPM_WORDS; i++) begin
            @(posedge sysclk);
            rx_word_valid_i <= 1'b1;
            rx_word_idx_i   <= ESPM_IDX_W'(i);
            rx_word_i       <= m_stage[i];
        end
        @(posedge sysclk);
        rx_word_valid_i <= 1'b0;
        rx_eof_i        <= 1'b1;
        rx_crc_good_i   <= crc_ok;
        @(posedge sysclk);
        rx_eof_i        <= 1'b0;
        rx_crc_good_i   <= 1'b0;
        commit_frame(crc_ok);
        repeat (80) @(posedge sysclk);          // Copy finishes well inside this
    endtask

    task automatic check_frame_state();
        int idx;
        @(negedge sysclk);
        check_equal(preload_good_o, m_preload_good, "preload_good_o");
        expect_reg({REGION_BOARD, BRD_CRC_GOOD}, m_good, "good frame count");
        expect_reg({REGION_BOARD, BRD_CRC_ERR}, m_err, "bad frame count");
        repeat (4) begin
            idx = $urandom % ESPM_WORDS;
            expect_reg({REGION_ESPM, 6'b0, ESPM_IDX_W'(idx)}, m_live[idx], "ESPM live word");
        end
    endtask

    task automatic write_preload(input int chan, input logic [ENC_W-1:0] val);
        @(posedge sysclk);
        reg_waddr_i <= {REGION_MAIN, 4'h0, 4'(chan), OFF_ENC_LOAD};
        reg_wdata_i <= {8'($urandom), val};     // Upper byte is ignored
        reg_wen_i   <= 1'b1;
        @(posedge sysclk);
        reg_wen_i   <= 1'b0;
        load_preload(chan, val);
    endtask

    task automatic check_encoders();
        for (int k = 1; k <= NUM_ENC; k++) begin
            expect_reg({REGION_MAIN, 4'h0, 4'(k), OFF_ENC_LOAD}, DATA_W'(m_preload[k]),
                       "encoder preload");
            expect_reg({REGION_MAIN, 4'h0, 4'(k), OFF_ENC_DATA}, adjusted_word(k),
                       "encoder adjusted position");
        end
    endtask

    task automatic drive_supply(input logic [MV_W-1:0] v);
        @(posedge sysclk);
        mv_sample_valid_i <= 1'b1;
        mv_sample_i       <= v;
        @(posedge sysclk);
        mv_sample_valid_i <= 1'b0;
        @(negedge sysclk);
        m_mv = v;
        check_equal(mv_good_o, supply_ok(v), "mv_good_o");
        expect_reg({REGION_BOARD, BRD_MV}, DATA_W'(v), "supply value");
    endtask

    task automatic wait_comm_good(input logic level, input int limit);
        int n;
        n = 0;
        while ((comm_good_o !== level) && (n < limit)) begin
            @(negedge sysclk);
            n++;
        end
        if (comm_good_o !== level) begin
            timeout_fail("the watchdog to change comm_good_o");
        end
        m_comm_good = level;
    endtask

    initial begin
        int               chan;
        int               n;
        logic [ENC_W-1:0] val;
        logic [MV_W-1:0]  mv;

        void'($urandom(18));
        arst_n_i          = 1'b0;
        rx_word_valid_i   = 1'b0;
        rx_word_idx_i     = '0;
        rx_word_i         = '0;
        rx_eof_i          = 1'b0;
        rx_crc_good_i     = 1'b0;
        mv_sample_valid_i = 1'b0;
        mv_sample_i       = '0;
        reg_raddr_i       = '0;
        reg_waddr_i       = '0;
        reg_wdata_i       = '0;
        reg_wen_i         = 1'b0;
        sample_start_i    = 1'b0;
        sample_raddr_i    = '0;
        reset_model();
        repeat (5) @(posedge sysclk);
        arst_n_i <= 1'b1;
        @(negedge sysclk);

        // --------------------------------------------------------------------
        // Reset state
        // --------------------------------------------------------------------
        check_equal(comm_good_o, 1'b0, "comm_good_o after reset");
        check_equal(mv_good_o, 1'b0, "mv_good_o after reset");
        check_equal(preload_good_o, 1'b0, "preload_good_o after reset");
        check_equal(sample_busy_o, 1'b0, "sample_busy_o after reset");
        expect_reg({REGION_BOARD, BRD_CRC_GOOD}, '0, "good count after reset");
        expect_reg({REGION_BOARD, BRD_CRC_ERR}, '0, "bad count after reset");
        expect_reg({REGION_BOARD, BRD_BUILD}, BUILD_NUMBER, "build number");
        expect_reg(16'h3000, FILL_WORD, "unmapped region");

        // Frames, about one in four bad, first one good
        for (int f = 0; f < 12; f++) begin
            send_frame((f == 0) || (($urandom % 4) != 0));
            check_frame_state();
        end
        for (int i = 0; i < ESPM_WORDS; i++) begin
            expect_reg({REGION_ESPM, 6'b0, ESPM_IDX_W'(i)}, m_live[i], "ESPM live word");
        end

        // --------------------------------------------------------------------
        // Encoder preload, values steered toward both ends of the range
        // --------------------------------------------------------------------
        for (int r = 0; r < 8; r++) begin
            repeat (3) begin
                chan = 1 + ($urandom % NUM_ENC);
                case ($urandom % 3)
                    0:       val = ENC_W'($urandom);
                    1:       val = ENC_W'($urandom % 2048);
                    default: val = {12'hFFF, 12'($urandom)};
                endcase
                write_preload(chan, val);
            end
            check_encoders();
            send_frame(1'b1);
            check_encoders();
        end

        // Supply window edges, then random samples
        for (int s = 0; s < 24; s++) begin
            case (s)
                0:       mv = MV_W'(MV_MIN);
                1:       mv = MV_W'(MV_MIN + 1);
                2:       mv = MV_W'(MV_MAX - 1);
                3:       mv = MV_W'(MV_MAX);
                4:       mv = MV_W'(MV_MIN - 1);
                5:       mv = MV_W'(MV_MAX + 1);
                6:       mv = 16'hFFFF;
                default: mv = (s % 2) ? MV_W'(MV_MIN + $urandom % (MV_MAX - MV_MIN + 1))
                                      : MV_W'($urandom);
            endcase
            drive_supply(mv);
        end

        // --------------------------------------------------------------------
        // Watchdog, silence then a single good frame
        // --------------------------------------------------------------------
        wait_comm_good(1'b0, 3 * WDOG_PERIOD);
        send_frame(1'b1);
        wait_comm_good(1'b1, 2 * WDOG_PERIOD);
        expect_reg({REGION_BOARD, BRD_HEALTH}, health_word(), "health word");

        // Block sampler
        @(posedge sysclk);
        sample_start_i <= 1'b1;
        @(posedge sysclk);
        sample_start_i <= 1'b0;
        @(negedge sysclk);
        n = 0;
        while ((sample_busy_o !== 1'b1) && (n < 10)) begin
            @(negedge sysclk);
            n++;
        end
        if (sample_busy_o !== 1'b1) begin
            timeout_fail("sample_busy_o to rise");
        end
        n = 0;
        while ((sample_busy_o === 1'b1) && (n < 4 * SAMPLE_WORDS)) begin
            @(negedge sysclk);
            n++;
        end
        if (sample_busy_o !== 1'b0) begin
            timeout_fail("sample_busy_o to fall");
        end
        check_equal(n, SAMPLE_WORDS + 1, "sampler busy length");
        for (int i = 0; i < SAMPLE_WORDS; i++) begin
            @(posedge sysclk);
            sample_raddr_i <= 3'(i);
            @(negedge sysclk);
            check_equal(sample_rdata_o, (i == 0) ? health_word() : adjusted_word(i),
                        "sample buffer entry");
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
